//--- bench/poly_engine_tb.sv
module poly_engine_tb;

    localparam int APB_TIMEOUT = 16;
    localparam int DONE_POLLS  = 200;
    localparam int DRAIN_LIMIT = 64;

    logic                        clk = 1'b0;
    logic                        arst_n;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [poly_pkg::APB_AW-1:0] paddr;
    logic [poly_pkg::APB_DW-1:0] pwdata;
    logic [poly_pkg::APB_DW-1:0] prdata;
    logic                        pready;
    logic                        pslverr;

    integer seed = 18629;

    // Shadow copies of both coefficient memories
    logic [poly_pkg::WORD_W-1:0] shadow_x [poly_pkg::DEPTH];
    logic [poly_pkg::WORD_W-1:0] shadow_y [poly_pkg::DEPTH];

    // Pending comparisons, observed against expected
    string       name_q [$];
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];

    poly_engine_top dut (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // One lane, straight from the modular rules
    function automatic logic [poly_pkg::COEF_W-1:0] lane_ref(input poly_pkg::lane_op_e op,
            input logic [poly_pkg::COEF_W-1:0] x, input logic [poly_pkg::COEF_W-1:0] y);
        int q;
        int r;
        q = int'(poly_pkg::MOD_Q);
        case (op)
            poly_pkg::OP_ADD: r = (int'(x) + int'(y)) % q;
            poly_pkg::OP_SUB: r = (int'(x) - int'(y) + q) % q;
            poly_pkg::OP_DBL: r = (2 * int'(x)) % q;
            default:          r = int'(y);
        endcase
        return poly_pkg::COEF_W'(r);
    endfunction

    function automatic logic [poly_pkg::WORD_W-1:0] word_ref(input poly_pkg::lane_op_e op,
            input logic [poly_pkg::WORD_W-1:0] x, input logic [poly_pkg::WORD_W-1:0] y);
        logic [poly_pkg::WORD_W-1:0] w;
        for (int l = 0; l < poly_pkg::LANES; l++) begin
            w[l*poly_pkg::COEF_W +: poly_pkg::COEF_W] =
                lane_ref(op, x[l*poly_pkg::COEF_W +: poly_pkg::COEF_W],
                         y[l*poly_pkg::COEF_W +: poly_pkg::COEF_W]);
        end
        return w;
    endfunction

    // Each lane already reduced below q
    function automatic logic [poly_pkg::WORD_W-1:0] rand_word();
        logic [poly_pkg::WORD_W-1:0] w;
        logic [31:0]                 r;
        for (int l = 0; l < poly_pkg::LANES; l++) begin
            r = $random(seed);
            w[l*poly_pkg::COEF_W +: poly_pkg::COEF_W] =
                poly_pkg::COEF_W'(r % 32'(poly_pkg::MOD_Q));
        end
        return w;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic go, input poly_pkg::lane_op_e op,
            input logic bank);
        return 32'({bank, op, go});
    endfunction

    function automatic logic [poly_pkg::APB_AW-1:0] win_addr(input logic bank, input int idx);
        return (bank ? poly_pkg::WIN_Y_BASE : poly_pkg::WIN_X_BASE) + poly_pkg::APB_AW'(idx * 4);
    endfunction

    // Sweep over words 0..len-1, old values in, one bank updated
    task automatic model_sweep(input poly_pkg::lane_op_e op, input logic bank, input int len);
        logic [poly_pkg::WORD_W-1:0] r;
        for (int i = 0; i < len; i++) begin
            r = word_ref(op, shadow_x[i], shadow_y[i]);
            if (bank) begin
                shadow_y[i] = r;
            end else begin
                shadow_x[i] = r;
            end
        end
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "timeout");
    endtask

    task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // Comparator, runs between rising edges
    always @(negedge clk) begin
        while (got_q.size() != 0) begin
            check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    //////////////////////////////
    // APB master
    //////////////////////////////

    // Setup, access, then wait for pready, sampled on the falling edge
    task automatic apb_xfer(input logic wr, input logic [poly_pkg::APB_AW-1:0] addr,
            input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
            output int waits);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready && waits < APB_TIMEOUT) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            report_timeout("pready on an APB transfer");
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [poly_pkg::APB_AW-1:0] addr, input logic [31:0] data,
            output logic err);
        logic [31:0] unused;
        int          waits;
        apb_xfer(1'b1, addr, data, unused, err, waits);
    endtask

    task automatic apb_read(input logic [poly_pkg::APB_AW-1:0] addr, output logic [31:0] data,
            output logic err, output int waits);
        apb_xfer(1'b0, addr, 32'h0, data, err, waits);
    endtask

    task automatic write_ok(input logic [poly_pkg::APB_AW-1:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        expect_word("pslverr", 32'(err), 32'h0);
    endtask

    task automatic read_expect(input string name, input logic [poly_pkg::APB_AW-1:0] addr,
            input logic [31:0] exp, input int exp_waits);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_read(addr, rd, err, waits);
        expect_word(name, rd, exp);
        expect_word("pslverr", 32'(err), 32'h0);
        expect_word("pready wait states", 32'(waits), 32'(exp_waits));
    endtask

    //////////////////////////////
    // Test steps
    //////////////////////////////

    task automatic fill_random();
        for (int i = 0; i < poly_pkg::DEPTH; i++) begin
            shadow_x[i] = rand_word();
            shadow_y[i] = rand_word();
            write_ok(win_addr(1'b0, i), 32'(shadow_x[i]));
            write_ok(win_addr(1'b1, i), 32'(shadow_y[i]));
        end
    endtask

    task automatic verify_all();
        for (int i = 0; i < poly_pkg::DEPTH; i++) begin
            read_expect($sformatf("x[%0d]", i), win_addr(1'b0, i), 32'(shadow_x[i]),
                        poly_pkg::RD_LAT);
            read_expect($sformatf("y[%0d]", i), win_addr(1'b1, i), 32'(shadow_y[i]),
                        poly_pkg::RD_LAT);
        end
    endtask

    // Poll STATUS until idle with done set
    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          waits;
        int          polls;
        polls = 0;
        st = '0;
        while (st[1:0] != 2'b10 && polls < DONE_POLLS) begin
            apb_read(poly_pkg::REG_STATUS, st, err, waits);
            polls++;
        end
        if (st[1:0] != 2'b10) begin
            report_timeout("sweep done in STATUS");
        end
    endtask

    task automatic run_sweep(input poly_pkg::lane_op_e op, input logic bank, input int len);
        write_ok(poly_pkg::REG_LEN, 32'(len));
        write_ok(poly_pkg::REG_CTRL, ctrl_word(1'b1, op, bank));
        // Start bit reads back as zero
        read_expect("ctrl", poly_pkg::REG_CTRL, ctrl_word(1'b0, op, bank), 0);
        wait_done();
        model_sweep(op, bank, len);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        logic [31:0] rd;
        logic        err;
        int          waits;

        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // Reset values and register readback
        read_expect("ctrl", poly_pkg::REG_CTRL, 32'h0, 0);
        read_expect("len", poly_pkg::REG_LEN, 32'h0, 0);
        read_expect("status", poly_pkg::REG_STATUS, 32'h0, 0);
        write_ok(poly_pkg::REG_LEN, 32'd37);
        read_expect("len", poly_pkg::REG_LEN, 32'd37, 0);
        write_ok(poly_pkg::REG_CTRL, ctrl_word(1'b0, poly_pkg::OP_DBL, 1'b1));
        read_expect("ctrl", poly_pkg::REG_CTRL, 32'hc, 0);
        read_expect("unmapped", 12'h010, 32'h0, 0);
        write_ok(poly_pkg::REG_CTRL, 32'h0);

        // Window write and readback
        fill_random();
        verify_all();

        // Every op, full length into Y
        for (int k = 0; k < 4; k++) begin
            fill_random();
            run_sweep(poly_pkg::lane_op_e'(k), 1'b1, poly_pkg::DEPTH);
            verify_all();
        end

        // In-place feedback, X becomes X + 2Y on the first 20 words
        fill_random();
        run_sweep(poly_pkg::OP_ADD, 1'b0, 20);
        run_sweep(poly_pkg::OP_ADD, 1'b0, 20);
        verify_all();

        // Access while busy, done still set from before
        read_expect("status", poly_pkg::REG_STATUS, 32'h2, 0);
        write_ok(poly_pkg::REG_LEN, 32'(poly_pkg::DEPTH));
        write_ok(poly_pkg::REG_CTRL, ctrl_word(1'b1, poly_pkg::OP_SUB, 1'b1));
        read_expect("status", poly_pkg::REG_STATUS, 32'h1, 0);
        apb_write(win_addr(1'b0, 5), 32'h00000abc, err);
        expect_word("pslverr", 32'(err), 32'h1);
        apb_read(win_addr(1'b1, 9), rd, err, waits);
        expect_word("pslverr", 32'(err), 32'h1);
        expect_word("prdata", rd, 32'h0);
        expect_word("pready wait states", 32'(waits), 32'h0);
        // Second start must not take effect
        write_ok(poly_pkg::REG_CTRL, ctrl_word(1'b1, poly_pkg::OP_DBL, 1'b0));
        read_expect("ctrl", poly_pkg::REG_CTRL, ctrl_word(1'b0, poly_pkg::OP_SUB, 1'b1), 0);
        wait_done();
        model_sweep(poly_pkg::OP_SUB, 1'b1, poly_pkg::DEPTH);
        verify_all();

        // Next start clears done
        write_ok(poly_pkg::REG_CTRL, ctrl_word(1'b1, poly_pkg::OP_PASS_Y, 1'b1));
        read_expect("status", poly_pkg::REG_STATUS, 32'h1, 0);
        wait_done();
        model_sweep(poly_pkg::OP_PASS_Y, 1'b1, poly_pkg::DEPTH);
        verify_all();

        // Let the comparator catch up
        waits = 0;
        while (got_q.size() != 0 && waits < DRAIN_LIMIT) begin
            @(posedge clk);
            waits++;
        end
        if (got_q.size() != 0) begin
            report_timeout("the comparison queue to empty");
        end
        @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the poly engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module poly_engine_tb \
    -f vlog.f \
    -o poly_engine_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/poly_engine_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Fail message found in $LOG"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

exit 0

//--- source/coef_ram.sv
module coef_ram (
    input  logic                        clk,
    input  logic                        we,
    input  logic [poly_pkg::ADDR_W-1:0] waddr,
    input  logic [poly_pkg::WORD_W-1:0] wdata,
    input  logic [poly_pkg::ADDR_W-1:0] raddr,
    output logic [poly_pkg::WORD_W-1:0] rdata
);

    // Word storage
    logic [poly_pkg::WORD_W-1:0] mem [poly_pkg::DEPTH];

    // Buffer stages ahead of the output register
    logic [poly_pkg::WORD_W-1:0] rd_buf1;
    logic [poly_pkg::WORD_W-1:0] rd_buf2;

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // Read pipeline
    //////////////////////////////

    // Array read, then two more registers
    // Data appears three edges after raddr settles
    always_ff @(posedge clk) begin
        rd_buf1 <= mem[raddr];
        rd_buf2 <= rd_buf1;
        rdata   <= rd_buf2;
    end

    // Writes from host or sweep must land inside the array
    a_waddr_range: assert property (
        @(posedge clk) we |-> (!$isunknown(waddr) && (int'(waddr) < poly_pkg::DEPTH))
    );

endmodule

//--- source/host_port.sv
module host_port (
    input  logic                        clk,
    input  logic                        arst_n,
    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [poly_pkg::APB_AW-1:0] paddr,
    input  logic [poly_pkg::APB_DW-1:0] pwdata,
    output logic [poly_pkg::APB_DW-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    // Sequencer control
    input  logic                        seq_busy,
    input  logic                        seq_done,
    output logic                        start,
    output poly_pkg::lane_op_e          op,
    output logic [poly_pkg::LEN_W-1:0]  len,
    output logic                        dst_bank,
    input  logic [poly_pkg::ADDR_W-1:0] seq_rd_addr,
    input  logic                        seq_wr_en,
    input  logic [poly_pkg::ADDR_W-1:0] seq_wr_addr,
    input  logic                        seq_wr_bank,
    // Memory ports
    output logic [poly_pkg::ADDR_W-1:0] ram_raddr,
    output logic                        ram_x_we,
    output logic                        ram_y_we,
    output logic [poly_pkg::ADDR_W-1:0] ram_waddr,
    output logic                        host_wdata_sel,
    input  logic [poly_pkg::WORD_W-1:0] ram_x_rdata,
    input  logic [poly_pkg::WORD_W-1:0] ram_y_rdata,
    input  logic [poly_pkg::WORD_W-1:0] z,
    output logic [poly_pkg::WORD_W-1:0] ram_wdata
);

    logic                          access_ph;
    logic                          in_x_win;
    logic                          in_y_win;
    logic                          in_win;
    logic [poly_pkg::APB_AW-1:0]   win_off;
    logic [poly_pkg::ADDR_W-1:0]   host_idx;
    logic                          reg_wr;
    logic                          mem_rd;
    logic                          mem_wr;
    logic                          rd_done;
    logic [poly_pkg::RD_CNT_W-1:0] rd_wait;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign access_ph = psel & penable;
    assign in_x_win  = (paddr >= poly_pkg::WIN_X_BASE) &&
                       (paddr < poly_pkg::WIN_X_BASE + poly_pkg::WIN_SPAN);
    assign in_y_win  = (paddr >= poly_pkg::WIN_Y_BASE) &&
                       (paddr < poly_pkg::WIN_Y_BASE + poly_pkg::WIN_SPAN);
    assign in_win    = in_x_win | in_y_win;

    // Byte offset into the window, word index from bit 2 up
    assign win_off  = paddr - (in_y_win ? poly_pkg::WIN_Y_BASE : poly_pkg::WIN_X_BASE);
    assign host_idx = win_off[poly_pkg::ADDR_W+1:2];

    assign reg_wr = access_ph & pwrite & ~in_win;
    assign mem_rd = access_ph & ~pwrite & in_win & ~seq_busy;
    assign mem_wr = access_ph & pwrite & in_win & ~seq_busy;

    //////////////////////////////
    // Control registers
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start    <= 1'b0;
            op       <= poly_pkg::OP_ADD;
            dst_bank <= 1'b0;
            len      <= '0;
        end else begin
            start <= 1'b0;
            // CTRL frozen during a sweep so op and bank stay put
            if (reg_wr && paddr == poly_pkg::REG_CTRL && !seq_busy) begin
                start    <= pwdata[0];
                op       <= poly_pkg::lane_op_e'(pwdata[2:1]);
                dst_bank <= pwdata[3];
            end
            if (reg_wr && paddr == poly_pkg::REG_LEN) begin
                len <= pwdata[poly_pkg::LEN_W-1:0];
            end
        end
    end

    // Read wait states while the memory pipeline fills
    assign rd_done = (rd_wait == poly_pkg::RD_CNT_W'(poly_pkg::RD_LAT));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_wait <= '0;
        end else if (mem_rd && !rd_done) begin
            rd_wait <= rd_wait + 1'b1;
        end else begin
            rd_wait <= '0;
        end
    end

    // Busy-time memory access ends at once with an error
    assign pready  = access_ph & (~mem_rd | rd_done);
    assign pslverr = access_ph & in_win & seq_busy;

    // Read data mux, unmapped reads zero
    always_comb begin
        prdata = '0;
        if (in_win) begin
            if (!seq_busy) begin
                prdata[poly_pkg::WORD_W-1:0] = in_y_win ? ram_y_rdata : ram_x_rdata;
            end
        end else if (paddr == poly_pkg::REG_CTRL) begin
            prdata[3:0] = {dst_bank, op, 1'b0};
        end else if (paddr == poly_pkg::REG_LEN) begin
            prdata[poly_pkg::LEN_W-1:0] = len;
        end else if (paddr == poly_pkg::REG_STATUS) begin
            prdata[1:0] = {seq_done, seq_busy};
        end
    end

    //////////////////////////////
    // Memory port arbitration
    //////////////////////////////

    // Sequencer owns both memories while busy
    assign host_wdata_sel = ~seq_busy;
    assign ram_wdata = host_wdata_sel ? pwdata[poly_pkg::WORD_W-1:0] : z;
    assign ram_raddr = seq_busy ? seq_rd_addr : host_idx;
    assign ram_waddr = seq_busy ? seq_wr_addr : host_idx;
    assign ram_x_we  = seq_busy ? (seq_wr_en & ~seq_wr_bank) : (mem_wr & in_x_win);
    assign ram_y_we  = seq_busy ? (seq_wr_en & seq_wr_bank) : (mem_wr & in_y_win);

    // One ready cycle per transfer
    a_pready_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        pready |=> !pready
    );

endmodule

//--- source/lane_preadder.sv
module lane_preadder (
    input  logic                        clk,
    input  logic                        arst_n,
    input  poly_pkg::lane_op_e          op,
    input  logic [poly_pkg::WORD_W-1:0] x,
    input  logic [poly_pkg::WORD_W-1:0] y,
    output logic [poly_pkg::WORD_W-1:0] z
);

    // Combinational result, all lanes
    logic [poly_pkg::WORD_W-1:0] z_next;

    //////////////////////////////
    // Per-lane modular arithmetic
    //////////////////////////////

    for (genvar i = 0; i < poly_pkg::LANES; i++) begin : g_lane
        logic [poly_pkg::COEF_W-1:0] xv;
        logic [poly_pkg::COEF_W-1:0] yv;
        // One extra bit for carry or borrow
        logic [poly_pkg::COEF_W:0]   raw;
        logic [poly_pkg::COEF_W:0]   fix;

        assign xv    = x[i*poly_pkg::COEF_W +: poly_pkg::COEF_W];
        assign yv    = y[i*poly_pkg::COEF_W +: poly_pkg::COEF_W];

        // Uncorrected value
        always_comb begin
            case (op)
                poly_pkg::OP_ADD: raw = {1'b0, xv} + {1'b0, yv};
                poly_pkg::OP_SUB: raw = {1'b0, xv} - {1'b0, yv};
                poly_pkg::OP_DBL: raw = {xv, 1'b0};
                default:          raw = {1'b0, yv};
            endcase
        end

        // Single correction step
        // Inputs below q keep raw within (-q, 2q)
        always_comb begin
            fix = raw;
            if (op == poly_pkg::OP_SUB) begin
                if (raw[poly_pkg::COEF_W]) begin
                    fix = raw + {1'b0, poly_pkg::MOD_Q};
                end
            end else if (raw >= {1'b0, poly_pkg::MOD_Q}) begin
                fix = raw - {1'b0, poly_pkg::MOD_Q};
            end
        end

        assign z_next[i*poly_pkg::COEF_W +: poly_pkg::COEF_W] = fix[poly_pkg::COEF_W-1:0];

        // Lanes arriving from memory are already reduced
        a_lane_reduced: assert property (
            @(posedge clk) disable iff (!arst_n)
            ($past(arst_n) && !$isunknown({xv, yv})) |->
                ((xv < poly_pkg::MOD_Q) && (yv < poly_pkg::MOD_Q))
        );
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Result lags rdata by one edge
    always_ff @(posedge clk) begin
        z <= z_next;
    end

endmodule

//--- source/poly_engine_top.sv
module poly_engine_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [poly_pkg::APB_AW-1:0] paddr,
    input  logic [poly_pkg::APB_DW-1:0] pwdata,
    output logic [poly_pkg::APB_DW-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr
);

    // Host to sequencer
    logic                        start;
    poly_pkg::lane_op_e          op;
    logic [poly_pkg::LEN_W-1:0]  len;
    logic                        dst_bank;
    logic                        seq_busy;
    logic                        seq_done;

    // Sequencer address and write strobes
    logic [poly_pkg::ADDR_W-1:0] seq_rd_addr;
    logic                        seq_wr_en;
    logic [poly_pkg::ADDR_W-1:0] seq_wr_addr;
    logic                        seq_wr_bank;

    // Shared memory ports
    logic [poly_pkg::ADDR_W-1:0] ram_raddr;
    logic                        ram_x_we;
    logic                        ram_y_we;
    logic [poly_pkg::ADDR_W-1:0] ram_waddr;
    logic [poly_pkg::WORD_W-1:0] ram_wdata;
    logic [poly_pkg::WORD_W-1:0] ram_x_rdata;
    logic [poly_pkg::WORD_W-1:0] ram_y_rdata;
    logic [poly_pkg::WORD_W-1:0] z;

    //////////////////////////////
    // Control
    //////////////////////////////

    host_port u_host (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .seq_busy(seq_busy), .seq_done(seq_done),
        .start(start), .op(op), .len(len), .dst_bank(dst_bank),
        .seq_rd_addr(seq_rd_addr), .seq_wr_en(seq_wr_en),
        .seq_wr_addr(seq_wr_addr), .seq_wr_bank(seq_wr_bank),
        .ram_raddr(ram_raddr), .ram_x_we(ram_x_we), .ram_y_we(ram_y_we),
        .ram_waddr(ram_waddr), .host_wdata_sel(),
        .ram_x_rdata(ram_x_rdata), .ram_y_rdata(ram_y_rdata),
        .z(z), .ram_wdata(ram_wdata)
    );

    sweep_sequencer u_seq (
        .clk(clk), .arst_n(arst_n),
        .start(start), .len(len), .dst_bank(dst_bank),
        .rd_addr(seq_rd_addr), .wr_en(seq_wr_en), .wr_addr(seq_wr_addr),
        .wr_bank(seq_wr_bank), .busy(seq_busy), .done(seq_done)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////

    // Both banks read the same word
    coef_ram ram_x (
        .clk(clk), .we(ram_x_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(ram_raddr), .rdata(ram_x_rdata)
    );

    coef_ram ram_y (
        .clk(clk), .we(ram_y_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(ram_raddr), .rdata(ram_y_rdata)
    );

    lane_preadder u_preadd (
        .clk(clk), .arst_n(arst_n), .op(op),
        .x(ram_x_rdata), .y(ram_y_rdata), .z(z)
    );

endmodule

//--- source/poly_pkg.sv
package poly_pkg;

    //////////////////////////////
    // Coefficient geometry
    //////////////////////////////

    // One lane holds a value reduced mod q
    localparam int COEF_W = 12;
    localparam int LANES  = 2;
    localparam int WORD_W = LANES * COEF_W;

    // Kyber-style modulus
    localparam logic [COEF_W-1:0] MOD_Q = 12'd3329;

    //////////////////////////////
    // Memory and pipeline
    //////////////////////////////

    localparam int DEPTH  = 64;
    localparam int ADDR_W = $clog2(DEPTH);

    // Registered read, three stages
    localparam int RD_LAT   = 3;
    localparam int RD_CNT_W = $clog2(RD_LAT + 1);

    // Read latency plus pre-adder register
    localparam int PIPE_D = RD_LAT + 1;

    // Word count field, 1..DEPTH
    localparam int LEN_W = 7;

    //////////////////////////////
    // APB register map
    //////////////////////////////

    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] REG_CTRL   = 12'h000;
    localparam logic [APB_AW-1:0] REG_LEN    = 12'h004;
    localparam logic [APB_AW-1:0] REG_STATUS = 12'h008;

    // Memory windows, one word per 4 bytes
    localparam logic [APB_AW-1:0] WIN_X_BASE = 12'h400;
    localparam logic [APB_AW-1:0] WIN_Y_BASE = 12'h800;
    localparam logic [APB_AW-1:0] WIN_SPAN   = 12'h100;

    // Per-lane pre-adder operation, CTRL bits 2:1
    typedef enum logic [1:0] {
        OP_ADD    = 2'd0,
        OP_SUB    = 2'd1,
        OP_DBL    = 2'd2,
        OP_PASS_Y = 2'd3
    } lane_op_e;

    // Sweep FSM
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2
    } sweep_state_e;

endpackage

//--- source/sweep_sequencer.sv
module sweep_sequencer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [poly_pkg::LEN_W-1:0]  len,
    input  logic                        dst_bank,
    output logic [poly_pkg::ADDR_W-1:0] rd_addr,
    output logic                        wr_en,
    output logic [poly_pkg::ADDR_W-1:0] wr_addr,
    output logic                        wr_bank,
    output logic                        busy,
    output logic                        done
);

    poly_pkg::sweep_state_e state;

    // Words still to issue
    logic [poly_pkg::LEN_W-1:0] remain;
    logic                       issue;

    // In-flight items, oldest at the top
    logic [poly_pkg::PIPE_D-1:0] vld_line;
    logic [poly_pkg::ADDR_W-1:0] addr_line [poly_pkg::PIPE_D];

    assign issue = (state == poly_pkg::ST_ISSUE);
    assign busy  = (state != poly_pkg::ST_IDLE);

    //////////////////////////////
    // Sweep FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= poly_pkg::ST_IDLE;
            rd_addr <= '0;
            remain  <= '0;
            wr_bank <= 1'b0;
            done    <= 1'b0;
        end else begin
            case (state)
                poly_pkg::ST_IDLE: begin
                    if (start) begin
                        // New start clears done even with LEN of zero
                        done    <= 1'b0;
                        rd_addr <= '0;
                        remain  <= len;
                        wr_bank <= dst_bank;
                        if (len != '0) begin
                            state <= poly_pkg::ST_ISSUE;
                        end
                    end
                end
                poly_pkg::ST_ISSUE: begin
                    // One address per cycle
                    rd_addr <= rd_addr + 1'b1;
                    remain  <= remain - 1'b1;
                    if (remain == poly_pkg::LEN_W'(1)) begin
                        state <= poly_pkg::ST_DRAIN;
                    end
                end
                poly_pkg::ST_DRAIN: begin
                    // Only the last item left, its write is this cycle
                    if (vld_line[poly_pkg::PIPE_D-2:0] == '0) begin
                        state <= poly_pkg::ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= poly_pkg::ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Valid and address line
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_line <= '0;
        end else begin
            vld_line <= {vld_line[poly_pkg::PIPE_D-2:0], issue};
        end
    end

    // Address tags follow the valid bits
    always_ff @(posedge clk) begin
        addr_line[0] <= rd_addr;
        for (int i = 1; i < poly_pkg::PIPE_D; i++) begin
            addr_line[i] <= addr_line[i-1];
        end
    end

    // Write-back lines up with the pre-adder result
    assign wr_en   = vld_line[poly_pkg::PIPE_D-1];
    assign wr_addr = addr_line[poly_pkg::PIPE_D-1];

    // Memory writes from the sweep only while it owns the ports
    a_wr_in_busy: assert property (
        @(posedge clk) disable iff (!arst_n) wr_en |-> busy
    );

endmodule

//--- vlog.f
source/poly_pkg.sv
source/coef_ram.sv
source/lane_preadder.sv
source/sweep_sequencer.sv
source/host_port.sv
source/poly_engine_top.sv
bench/poly_engine_tb.sv
